// File: list.f
logic/tile_pkg.sv
logic/wb_bus_arbiter.sv
logic/wb_bus.sv
logic/wb_sram_sp.sv
logic/wb_bootrom.sv
logic/tile_top.sv
tb/tile_sva.sv
tb/tile_tb.sv

// File: logic/tile_pkg.sv
// Tile bus package
// Widths, address map, Wishbone bus structs and the boot image
package tile_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int SEL_W      = DATA_W / 8;
  localparam int NR_MASTERS = 2;
  localparam int OWNER_W    = $clog2(NR_MASTERS);

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [SEL_W-1:0]   sel_t;
  typedef logic [OWNER_W-1:0] owner_t;

  //////////////////////////////
  // Address map
  //////////////////////////////
  localparam int REGION_W = 4;
  localparam logic [REGION_W-1:0] REGION_MEM  = 4'h0;
  localparam logic [REGION_W-1:0] REGION_EXT  = 4'he;
  localparam logic [REGION_W-1:0] REGION_BOOT = 4'hf;

  localparam int LMEM_WORDS = 256;
  localparam int LMEM_AW    = $clog2(LMEM_WORDS);
  localparam int BOOT_WORDS = 16;
  localparam int BOOT_AW    = $clog2(BOOT_WORDS);

  // Boot image, one word per entry
  localparam data_t BOOTROM_IMAGE [BOOT_WORDS] = '{
    32'h1800_0000, 32'ha840_0000, 32'h1860_e000, 32'ha863_0100,
    32'hd403_1000, 32'h8480_0000, 32'he084_2000, 32'hbc04_0000,
    32'h0fff_fffd, 32'h1500_0000, 32'h4400_4800, 32'h1500_0000,
    32'h9c21_fff8, 32'hd401_4800, 32'h8521_0000, 32'h0000_0000
  };

  //////////////////////////////
  // Wishbone structs
  //////////////////////////////
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    sel_t  sel;
    addr_t adr;
    data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {MEM, EXT, BOOT, NONE} region_e;

endpackage

// File: logic/tile_top.sv
// Tile top level
// Shared bus with local memory, boot ROM and the external slave port
`timescale 1ns/1ps

module tile_top
  import tile_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // Instruction port is master 0, data port is master 1
  input  wb_req_t [NR_MASTERS-1:0] m_req_i,
  output wb_rsp_t [NR_MASTERS-1:0] m_rsp_o,

  // Network adapter region
  output wb_req_t                  ext_req_o,
  input  wb_rsp_t                  ext_rsp_i
);

  wb_req_t mem_req;
  wb_rsp_t mem_rsp;
  wb_req_t boot_req;
  wb_rsp_t boot_rsp;

  //////////////////////////////
  // Bus
  //////////////////////////////
  wb_bus u_bus (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .m_req_i    (m_req_i),
    .m_rsp_o    (m_rsp_o),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp),
    .boot_req_o (boot_req),
    .boot_rsp_i (boot_rsp),
    .ext_req_o  (ext_req_o),
    .ext_rsp_i  (ext_rsp_i)
  );

  //////////////////////////////
  // On-tile slaves
  //////////////////////////////
  wb_sram_sp u_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (mem_req),
    .rsp_o   (mem_rsp)
  );

  wb_bootrom u_bootrom (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (boot_req),
    .rsp_o   (boot_rsp)
  );

endmodule

// File: logic/wb_bootrom.sv
// Boot ROM slave
// Returns the fixed boot image with a registered ack
`timescale 1ns/1ps

module wb_bootrom
  import tile_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  logic [BOOT_AW-1:0] word_idx;
  logic               access;
  logic               ack_q;
  data_t              rdata_q;

  // Only the low word bits select, higher ones wrap
  assign word_idx = req_i.adr[BOOT_AW+1:2];
  assign access   = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= BOOTROM_IMAGE[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = rdata_q;

endmodule

// File: logic/wb_bus.sv
// Shared tile bus
// Routes the owning master to local memory, boot ROM or the external
// port by address region, and answers unmapped accesses with err
`timescale 1ns/1ps

module wb_bus
  import tile_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  wb_req_t [NR_MASTERS-1:0] m_req_i,
  output wb_rsp_t [NR_MASTERS-1:0] m_rsp_o,
  output wb_req_t                  mem_req_o,
  input  wb_rsp_t                  mem_rsp_i,
  output wb_req_t                  boot_req_o,
  input  wb_rsp_t                  boot_rsp_i,
  output wb_req_t                  ext_req_o,
  input  wb_rsp_t                  ext_rsp_i
);

  logic [NR_MASTERS-1:0] cyc_vec;
  owner_t  owner;
  logic    owner_valid;
  wb_req_t own_req;
  region_e region;
  logic    bad_access;
  logic    own_stb;
  logic    err_q;
  wb_rsp_t sel_rsp;

  always_comb begin
    for (int m = 0; m < NR_MASTERS; m++) begin
      cyc_vec[m] = m_req_i[m].cyc;
    end
  end

  wb_bus_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cyc_i         (cyc_vec),
    .owner_o       (owner),
    .owner_valid_o (owner_valid)
  );

  assign own_req = m_req_i[owner];
  assign own_stb = owner_valid & own_req.cyc & own_req.stb;

  //////////////////////////////
  // Region decode
  //////////////////////////////
  always_comb begin
    case (own_req.adr[ADDR_W-1 -: REGION_W])
      REGION_MEM:  region = MEM;
      REGION_EXT:  region = EXT;
      REGION_BOOT: region = BOOT;
      default:     region = NONE;
    endcase
  end

  // ROM writes never reach the ROM
  assign bad_access = (region == NONE) | ((region == BOOT) & own_req.we);

  //////////////////////////////
  // Slave requests
  //////////////////////////////
  always_comb begin
    mem_req_o      = own_req;
    mem_req_o.cyc  = own_req.cyc & owner_valid & (region == MEM);
    mem_req_o.stb  = own_req.stb & owner_valid & (region == MEM);
    boot_req_o     = own_req;
    boot_req_o.cyc = own_req.cyc & owner_valid & (region == BOOT) & ~own_req.we;
    boot_req_o.stb = own_req.stb & owner_valid & (region == BOOT) & ~own_req.we;
    ext_req_o      = own_req;
    ext_req_o.cyc  = own_req.cyc & owner_valid & (region == EXT);
    ext_req_o.stb  = own_req.stb & owner_valid & (region == EXT);
  end

  // One-cycle err, same latency as the on-tile slaves
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= own_stb & bad_access & ~err_q;
    end
  end

  //////////////////////////////
  // Response return
  //////////////////////////////
  always_comb begin
    if (bad_access) begin
      sel_rsp = '{ack: 1'b0, err: err_q, dat: '0};
    end else if (region == MEM) begin
      sel_rsp = mem_rsp_i;
    end else if (region == EXT) begin
      sel_rsp = ext_rsp_i;
    end else begin
      sel_rsp = boot_rsp_i;
    end
    for (int m = 0; m < NR_MASTERS; m++) begin
      m_rsp_o[m] = (owner_valid && owner == owner_t'(m)) ? sel_rsp : '0;
    end
  end

endmodule

// File: logic/wb_bus_arbiter.sv
// Round-robin bus arbiter
// Grants the bus to one master and holds it for the whole cycle
`timescale 1ns/1ps

module wb_bus_arbiter
  import tile_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [NR_MASTERS-1:0] cyc_i,
  output owner_t                owner_o,
  output logic                  owner_valid_o
);

  // Keeps the last owner after release, so it is also the rr pointer
  owner_t owner_q;
  logic   valid_q;
  owner_t next_owner;
  logic   next_found;

  //////////////////////////////
  // Next owner search
  //////////////////////////////
  // Priority starts right after the last owner
  always_comb begin
    next_owner = owner_q;
    next_found = 1'b0;
    for (int i = 1; i <= NR_MASTERS; i++) begin
      if (!next_found && cyc_i[(int'(owner_q) + i) % NR_MASTERS]) begin
        next_owner = owner_t'((int'(owner_q) + i) % NR_MASTERS);
        next_found = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Ownership register
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // Master 0 gets first pick after reset
      owner_q <= owner_t'(NR_MASTERS - 1);
      valid_q <= 1'b0;
    end else if (valid_q) begin
      // Release once the owner drops cyc
      if (!cyc_i[owner_q]) begin
        valid_q <= 1'b0;
      end
    end else if (next_found) begin
      owner_q <= next_owner;
      valid_q <= 1'b1;
    end
  end

  assign owner_o       = owner_q;
  assign owner_valid_o = valid_q;

endmodule

// File: logic/wb_sram_sp.sv
// Local memory slave
// Single-port word memory with byte selects and a registered ack
`timescale 1ns/1ps

module wb_sram_sp
  import tile_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  data_t mem [LMEM_WORDS];

  logic [LMEM_AW-1:0] word_idx;
  logic               access;
  logic               ack_q;
  data_t              rdata_q;

  // Upper address bits are ignored, so the region wraps
  assign word_idx = req_i.adr[LMEM_AW+1:2];

  // Ack register blocks a second access on the same strobe
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  //////////////////////////////
  // Storage
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (access && req_i.we) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (req_i.sel[b]) begin
          mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
    end
  end

  // Read data is taken before any write of the same cycle
  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = rdata_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the tile testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tile_sim

rm -rf obj_dir

if ! verilator --binary --timing --assert --top-module tile_tb -f list.f -o "$BIN"; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
  exit 0
fi

echo "pass message not found in $LOG"
exit 1

// File: tb/tile_sva.sv
// Bus protocol assertions
// Bound to the shared bus to watch slave strobes, ownership and responses
`timescale 1ns/1ps

module tile_sva
  import tile_pkg::*;
(
  input logic                     clk_i,
  input logic                     rst_n_i,
  input wb_req_t [NR_MASTERS-1:0] m_req_i,
  input wb_rsp_t [NR_MASTERS-1:0] m_rsp_i,
  input wb_req_t                  mem_req_i,
  input wb_req_t                  boot_req_i,
  input wb_req_t                  ext_req_i,
  input owner_t                   owner_i,
  input logic                     owner_valid_i
);

  // At most one slave strobed
  a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({mem_req_i.stb, boot_req_i.stb, ext_req_i.stb}))
    else $error("more than one slave strobe high");

  for (genvar m = 0; m < NR_MASTERS; m++) begin : g_master
    // Responses only reach the owner with its strobe up
    a_rsp_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (m_rsp_i[m].ack || m_rsp_i[m].err) |->
        (owner_valid_i && owner_i == owner_t'(m) && m_req_i[m].stb))
      else $error("master %0d got a response without owning the bus", m);

    a_ack_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(m_rsp_i[m].ack && m_rsp_i[m].err))
      else $error("master %0d saw ack and err together", m);
  end

endmodule

bind wb_bus tile_sva u_sva (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .m_req_i       (m_req_i),
  .m_rsp_i       (m_rsp_o),
  .mem_req_i     (mem_req_o),
  .boot_req_i    (boot_req_o),
  .ext_req_i     (ext_req_o),
  .owner_i       (owner),
  .owner_valid_i (owner_valid)
);

// File: tb/tile_tb.sv
// Tile bus testbench
// Drives both master ports of the tile top level through directed tests
// and models the external slave on the network-adapter port
`timescale 1ns/1ps

module tile_tb
  import tile_pkg::*;
();

  localparam int WAIT_LIMIT = 40;

  logic                     clk_i;
  logic                     rst_n_i;
  wb_req_t                  drv_req [NR_MASTERS];
  wb_req_t [NR_MASTERS-1:0] m_req;
  wb_rsp_t [NR_MASTERS-1:0] m_rsp;
  wb_req_t                  ext_req;
  wb_rsp_t                  ext_rsp;

  int    seed;
  int    errors;
  int    checks;
  int    timeouts;
  data_t lmem_model [LMEM_WORDS];

  // External slave model state
  data_t      ext_mem [16];
  wb_req_t    ext_seen;
  wb_req_t    ext_last;
  logic [3:0] ext_idx;

  tile_top uut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .m_req_i   (m_req),
    .m_rsp_o   (m_rsp),
    .ext_req_o (ext_req),
    .ext_rsp_i (ext_rsp)
  );

  // Each master process drives its own entry
  always_comb begin
    for (int m = 0; m < NR_MASTERS; m++) begin
      m_req[m] = drv_req[m];
    end
  end

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                        input sel_t sel);
    data_t res;
    res = old_w;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Fill word of the external model, built from the whole word index
  function automatic data_t ext_fill(input logic [3:0] idx);
    return {16'hc0de, idx, ~idx, idx, ~idx};
  endfunction

  // Upper pad bits sit above the memory size and must wrap
  function automatic addr_t lmem_addr(input logic [7:0] idx, input logic [17:0] pad);
    return {REGION_MEM, pad, idx, 2'b00};
  endfunction

  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // One Wishbone transfer, ended by ack or err
  task automatic bus_access(input owner_t m, input logic we, input addr_t adr,
                            input data_t wdat, input sel_t sel, output data_t rdat,
                            output logic got_ack, output logic got_err);
    logic done;
    done    = 1'b0;
    got_ack = 1'b0;
    got_err = 1'b0;
    rdat    = '0;
    @(posedge clk_i);
    #1;
    drv_req[m] = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
    for (int n = 0; n < WAIT_LIMIT && !done; n++) begin
      @(negedge clk_i);
      if (m_rsp[m].ack || m_rsp[m].err) begin
        done    = 1'b1;
        got_ack = m_rsp[m].ack;
        got_err = m_rsp[m].err;
        rdat    = m_rsp[m].dat;
      end
    end
    if (!done) begin
      timeouts++;
      $display("timeout: master %0d got no ack or err for address %h", m, adr);
    end
    @(posedge clk_i);
    #1;
    drv_req[m] = '0;
  endtask

  task automatic mem_write(input owner_t m, input addr_t adr, input data_t dat,
                           input sel_t sel);
    data_t rd;
    logic  ack;
    logic  err;
    bus_access(m, 1'b1, adr, dat, sel, rd, ack, err);
    check_value("m_rsp_o.ack", data_t'(ack), 32'h1);
    check_value("m_rsp_o.err", data_t'(err), 32'h0);
  endtask

  task automatic mem_read(input owner_t m, input addr_t adr, input data_t exp);
    data_t rd;
    logic  ack;
    logic  err;
    bus_access(m, 1'b0, adr, '0, 4'hf, rd, ack, err);
    check_value("m_rsp_o.ack", data_t'(ack), 32'h1);
    check_value("m_rsp_o.err", data_t'(err), 32'h0);
    check_value("m_rsp_o.dat", rd, exp);
  endtask

  task automatic expect_err(input owner_t m, input logic we, input addr_t adr);
    data_t rd;
    logic  ack;
    logic  err;
    bus_access(m, we, adr, 32'hdead_beef, 4'hf, rd, ack, err);
    check_value("m_rsp_o.err", data_t'(err), 32'h1);
    check_value("m_rsp_o.ack", data_t'(ack), 32'h0);
  endtask

  //////////////////////////////
  // External slave model
  //////////////////////////////
  initial begin
    for (int i = 0; i < 16; i++) begin
      ext_mem[4'(i)] = ext_fill(4'(i));
    end
    ext_rsp  = '0;
    ext_seen = '0;
    ext_last = '0;
    ext_idx  = '0;
    forever begin
      @(negedge clk_i);
      ext_seen = ext_req;
      @(posedge clk_i);
      #1;
      if (ext_seen.cyc && ext_seen.stb && !ext_rsp.ack) begin
        ext_idx  = ext_seen.adr[5:2];
        ext_last = ext_seen;
        if (ext_seen.we) begin
          ext_mem[ext_idx] = merge_bytes(ext_mem[ext_idx], ext_seen.dat, ext_seen.sel);
        end
        ext_rsp = '{ack: 1'b1, err: 1'b0, dat: ext_mem[ext_idx]};
      end else begin
        ext_rsp = '0;
      end
    end
  end

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic check_idle();
    repeat (4) begin
      @(negedge clk_i);
      check_value("m_rsp_o.ack/err",
                  data_t'({m_rsp[0].ack, m_rsp[0].err, m_rsp[1].ack, m_rsp[1].err}), 32'h0);
      check_value("ext_req_o.cyc/stb", data_t'({ext_req.cyc, ext_req.stb}), 32'h0);
    end
  endtask

  task automatic test_local_memory();
    logic [7:0] idx [8];
    sel_t       sel_list [4];
    data_t      r;
    sel_list[0] = 4'b0001;
    sel_list[1] = 4'b0110;
    sel_list[2] = 4'b1000;
    sel_list[3] = 4'b1010;
    for (int k = 0; k < 8; k++) begin
      r      = $random(seed);
      idx[k] = r[7:0];
      r      = $random(seed);
      mem_write(owner_t'(k % 2), lmem_addr(idx[k], 18'h0), r, 4'hf);
      lmem_model[idx[k]] = r;
    end
    // Partial writes keep the bytes with a clear select
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      mem_write(owner_t'((k + 1) % 2), lmem_addr(idx[k], 18'(k)), r, sel_list[k % 4]);
      lmem_model[idx[k]] = merge_bytes(lmem_model[idx[k]], r, sel_list[k % 4]);
    end
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      mem_read(owner_t'(k % 2), lmem_addr(idx[k], r[17:0]), lmem_model[idx[k]]);
    end
  endtask

  task automatic test_boot_rom();
    data_t r;
    for (int k = 0; k < BOOT_WORDS; k++) begin
      mem_read(owner_t'(k % 2), {REGION_BOOT, 22'h0, 4'(k), 2'b00}, BOOTROM_IMAGE[4'(k)]);
    end
    // Wrapped addresses
    repeat (4) begin
      r = $random(seed);
      mem_read(1'b1, {REGION_BOOT, r[27:0]}, BOOTROM_IMAGE[r[5:2]]);
    end
    expect_err(1'b1, 1'b1, 32'hf000_0008);
    expect_err(1'b0, 1'b1, 32'hf000_0000);
    mem_read(1'b0, 32'hf000_0008, BOOTROM_IMAGE[2]);
    mem_read(1'b1, 32'hf000_0000, BOOTROM_IMAGE[0]);
  endtask

  task automatic test_external();
    data_t r;
    r = $random(seed);
    mem_write(1'b1, 32'he000_0014, r, 4'b0110);
    check_value("ext_req_o.adr", ext_last.adr, 32'he000_0014);
    check_value("ext_req_o.dat", ext_last.dat, r);
    check_value("ext_req_o.sel", data_t'(ext_last.sel), 32'h6);
    check_value("ext_req_o.we", data_t'(ext_last.we), 32'h1);
    mem_read(1'b0, 32'he000_0014, merge_bytes(ext_fill(4'h5), r, 4'b0110));
    mem_read(1'b1, 32'he000_0020, ext_fill(4'h8));
  endtask

  task automatic test_unmapped();
    expect_err(1'b0, 1'b0, 32'h1000_0000);
    expect_err(1'b1, 1'b1, 32'h4000_0100);
    expect_err(1'b0, 1'b1, 32'h8abc_def0);
    expect_err(1'b1, 1'b0, 32'hd000_0004);
    expect_err(1'b0, 1'b0, 32'h7fff_fffc);
  endtask

  task automatic run_concurrent();
    data_t      r;
    data_t      da;
    data_t      db;
    logic [7:0] ia;
    logic [7:0] ib;
    for (int k = 0; k < 4; k++) begin
      r  = $random(seed);
      ia = r[7:0];
      ib = ia ^ 8'h80;
      da = $random(seed);
      db = $random(seed);
      fork
        mem_write(1'b0, lmem_addr(ia, 18'h0), da, 4'hf);
        mem_write(1'b1, lmem_addr(ib, 18'h0), db, 4'hf);
      join
      lmem_model[ia] = da;
      lmem_model[ib] = db;
      fork
        mem_read(1'b1, lmem_addr(ia, 18'h3), lmem_model[ia]);
        mem_read(1'b0, lmem_addr(ib, 18'h5), lmem_model[ib]);
      join
    end
    fork
      mem_read(1'b0, 32'hf000_000c, BOOTROM_IMAGE[3]);
      mem_read(1'b1, 32'he000_0020, ext_fill(4'h8));
    join
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    seed       = 32'h7bc1;
    errors     = 0;
    checks     = 0;
    timeouts   = 0;
    rst_n_i    = 1'b0;
    drv_req[0] = '0;
    drv_req[1] = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    check_idle();
    test_local_memory();
    test_boot_rom();
    test_external();
    test_unmapped();
    run_concurrent();
    repeat (4) @(posedge clk_i);

    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
